// ==== rv32i_pkg.sv ====
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;     // Data word, pc and target
    typedef logic [4:0]  rv32i_reg;      // Register index
    typedef logic [6:0]  rv32i_opcode_t; // Major opcode field

    // RV32I major opcodes covered by this slice
    localparam rv32i_opcode_t OP_LUI   = 7'b0110111;
    localparam rv32i_opcode_t OP_AUIPC = 7'b0010111;
    localparam rv32i_opcode_t OP_JAL   = 7'b1101111;
    localparam rv32i_opcode_t OP_JALR  = 7'b1100111;
    localparam rv32i_opcode_t OP_BR    = 7'b1100011;
    localparam rv32i_opcode_t OP_IMM   = 7'b0010011;
    localparam rv32i_opcode_t OP_REG   = 7'b0110011;

    // funct3 values of the arithmetic and logic group
    localparam logic [2:0] F3_ADD  = 3'b000; // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // SRL or SRA as told apart by funct7 bit 5
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_ops_t;

    // Encoded as the BRANCH funct3 field so decode can map it directly
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic {mux1_rs1, mux1_pc} alumux1_sel_t;

    typedef enum logic {mux2_imm, mux2_rs2} alumux2_sel_t;

    typedef enum logic [1:0] {fwd_reg, fwd_exe, fwd_mem} fwd_sel_t;

    typedef enum logic {res_alu, res_pc4} result_sel_t;

endpackage

// ==== alu.sv ====
`timescale 1ns/1ns

module alu
    import rv32i_pkg::*;
(
    input  alu_ops_t  aluop_i,
    input  rv32i_word a_i,
    input  rv32i_word b_i,
    output rv32i_word f_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0]; // Only the low five bits count for shifts

    always_comb begin
        case (aluop_i)
            alu_add:  f_o = a_i + b_i;
            alu_sub:  f_o = a_i - b_i;
            alu_sll:  f_o = a_i << shamt;
            alu_slt:  f_o = {31'b0, $signed(a_i) < $signed(b_i)};
            alu_sltu: f_o = {31'b0, a_i < b_i};
            alu_xor:  f_o = a_i ^ b_i;
            alu_srl:  f_o = a_i >> shamt;
            alu_sra:  f_o = rv32i_word'($signed(a_i) >>> shamt);
            alu_or:   f_o = a_i | b_i;
            alu_and:  f_o = a_i & b_i;
            default:  f_o = '0;
        endcase
    end

endmodule

// ==== cmp.sv ====
`timescale 1ns/1ns

module cmp
    import rv32i_pkg::*;
(
    input  branch_funct3_t cmpop_i,
    input  rv32i_word      a_i,
    input  rv32i_word      b_i,
    output logic           br_en_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a_i == b_i);
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    always_comb begin
        case (cmpop_i)
            beq:     br_en_o = eq;
            bne:     br_en_o = ~eq;
            blt:     br_en_o = lt_s;
            bge:     br_en_o = ~lt_s;
            bltu:    br_en_o = lt_u;
            bgeu:    br_en_o = ~lt_u;
            default: br_en_o = 1'b0;
        endcase
    end

endmodule

// ==== ctrl_decode.sv ====
`timescale 1ns/1ns

module ctrl_decode
    import rv32i_pkg::*;
(
    input  logic [31:0]    instr_i,
    input  logic           valid_i,
    output logic           valid_o,
    output rv32i_reg       rs1_o,
    output rv32i_reg       rs2_o,
    output rv32i_reg       rd_o,
    output alu_ops_t       aluop_o,
    output branch_funct3_t cmpop_o,
    output alumux1_sel_t   alumux1_sel_o,
    output alumux2_sel_t   alumux2_sel_o,
    output result_sel_t    result_sel_o,
    output logic           is_branch_o,
    output logic           is_jump_o,
    output rv32i_word      imm_o
);

    rv32i_opcode_t opcode;
    logic [2:0]    funct3;
    logic          alt;      // funct7 bit 5
    rv32i_word     i_imm;
    rv32i_word     u_imm;
    rv32i_word     b_imm;
    rv32i_word     j_imm;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign alt    = instr_i[30];

    assign i_imm = {{21{instr_i[31]}}, instr_i[30:20]};
    assign u_imm = {instr_i[31:12], 12'b0};
    assign b_imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign j_imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    // SUB only exists in the register form, SRA in both forms
    function automatic alu_ops_t alu_decode(input logic [2:0] f3,
                                            input logic sub_en,
                                            input logic sra_en);
        case (f3)
            F3_ADD:  alu_decode = sub_en ? alu_sub : alu_add;
            F3_SLL:  alu_decode = alu_sll;
            F3_SLT:  alu_decode = alu_slt;
            F3_SLTU: alu_decode = alu_sltu;
            F3_XOR:  alu_decode = alu_xor;
            F3_SR:   alu_decode = sra_en ? alu_sra : alu_srl;
            F3_OR:   alu_decode = alu_or;
            default: alu_decode = alu_and;
        endcase
    endfunction

    always_comb begin
        valid_o       = valid_i;
        rs1_o         = instr_i[19:15];
        rs2_o         = instr_i[24:20];
        rd_o          = instr_i[11:7];
        aluop_o       = alu_add;
        cmpop_o       = beq;
        alumux1_sel_o = mux1_rs1;
        alumux2_sel_o = mux2_imm;
        result_sel_o  = res_alu;
        is_branch_o   = 1'b0;
        is_jump_o     = 1'b0;
        imm_o         = i_imm;

        case (opcode)
            OP_LUI: begin
                rs1_o = '0;      // x0 plus the upper immediate
                imm_o = u_imm;
            end
            OP_AUIPC: begin
                alumux1_sel_o = mux1_pc;
                imm_o         = u_imm;
            end
            OP_JAL: begin
                alumux1_sel_o = mux1_pc;
                imm_o         = j_imm;
                result_sel_o  = res_pc4;
                is_jump_o     = 1'b1;
            end
            OP_JALR: begin
                result_sel_o = res_pc4; // Target is rs1 plus the I immediate
                is_jump_o    = 1'b1;
            end
            OP_BR: begin
                rd_o          = '0;     // Branches write nothing back
                alumux1_sel_o = mux1_pc;
                imm_o         = b_imm;
                is_branch_o   = 1'b1;
                case (funct3)
                    3'b000:  cmpop_o = beq;
                    3'b001:  cmpop_o = bne;
                    3'b100:  cmpop_o = blt;
                    3'b101:  cmpop_o = bge;
                    3'b110:  cmpop_o = bltu;
                    3'b111:  cmpop_o = bgeu;
                    default: valid_o = 1'b0; // Reserved condition becomes a bubble
                endcase
            end
            OP_IMM: aluop_o = alu_decode(funct3, 1'b0, alt);
            OP_REG: begin
                alumux2_sel_o = mux2_rs2;
                aluop_o       = alu_decode(funct3, alt, alt);
            end
            default: valid_o = 1'b0;
        endcase
    end

endmodule

// ==== fwd_unit.sv ====
`timescale 1ns/1ns

module fwd_unit
    import rv32i_pkg::*;
(
    input  rv32i_reg rs1_i,
    input  rv32i_reg rs2_i,
    input  logic     exm_valid_i,
    input  logic     mwb_valid_i,
    input  rv32i_reg exm_rd_i,
    input  rv32i_reg mwb_rd_i,
    output fwd_sel_t rs1_sel_o,
    output fwd_sel_t rs2_sel_o
);

    // The younger producer in execute/memory takes priority over memory/writeback
    function automatic fwd_sel_t pick(input rv32i_reg rs);
        if (rs == '0)
            pick = fwd_reg;   // x0 always reads as zero from the register file
        else if (exm_valid_i && (rs == exm_rd_i))
            pick = fwd_exe;
        else if (mwb_valid_i && (rs == mwb_rd_i))
            pick = fwd_mem;
        else
            pick = fwd_reg;
    endfunction

    assign rs1_sel_o = pick(rs1_i);
    assign rs2_sel_o = pick(rs2_i);

endmodule

// ==== exe_stage.sv ====
`timescale 1ns/1ns

module exe_stage
    import rv32i_pkg::*;
(
    input  alu_ops_t       aluop_i,
    input  branch_funct3_t cmpop_i,
    input  alumux1_sel_t   alumux1_sel_i,
    input  alumux2_sel_t   alumux2_sel_i,
    input  result_sel_t    result_sel_i,
    input  logic           is_branch_i,
    input  logic           is_jump_i,
    input  rv32i_word      imm_i,
    input  rv32i_word      pc_i,
    input  rv32i_word      rs1_data_i,
    input  rv32i_word      rs2_data_i,
    input  rv32i_word      exe_fwd_i,
    input  rv32i_word      mem_fwd_i,
    input  fwd_sel_t       rs1_sel_i,
    input  fwd_sel_t       rs2_sel_i,
    output rv32i_word      result_o,
    output rv32i_word      target_o,
    output logic           br_en_o
);

    rv32i_word rs1_val;
    rv32i_word rs2_val;
    rv32i_word alu_a;
    rv32i_word alu_b;
    rv32i_word alu_out;
    logic      cmp_out;

    always_comb begin
        case (rs1_sel_i)
            fwd_exe: rs1_val = exe_fwd_i;
            fwd_mem: rs1_val = mem_fwd_i;
            default: rs1_val = rs1_data_i;
        endcase

        case (rs2_sel_i)
            fwd_exe: rs2_val = exe_fwd_i;
            fwd_mem: rs2_val = mem_fwd_i;
            default: rs2_val = rs2_data_i;
        endcase
    end

    assign alu_a = (alumux1_sel_i == mux1_pc)  ? pc_i    : rs1_val;
    assign alu_b = (alumux2_sel_i == mux2_rs2) ? rs2_val : imm_i;

    alu u_alu (
        .aluop_i (aluop_i),
        .a_i     (alu_a),
        .b_i     (alu_b),
        .f_o     (alu_out)
    );

    cmp u_cmp (
        .cmpop_i (cmpop_i),
        .a_i     (rs1_val),
        .b_i     (rs2_val),
        .br_en_o (cmp_out)
    );

    // Link value for jumps, ALU output for everything else
    assign result_o = (result_sel_i == res_pc4) ? pc_i + 32'd4 : alu_out;

    always_comb begin
        target_o = '0;
        if (is_jump_i && (alumux1_sel_i == mux1_rs1))
            target_o = {alu_out[31:1], 1'b0}; // JALR drops bit 0 of the sum
        else if (is_jump_i || is_branch_i)
            target_o = alu_out;
    end

    assign br_en_o = is_jump_i | (is_branch_i & cmp_out);

endmodule

// ==== pipe_regs.sv ====
`timescale 1ns/1ns

module pipe_regs
    import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      valid_i,
    input  rv32i_reg  rd_i,
    input  rv32i_word result_i,
    input  rv32i_word target_i,
    input  logic      br_en_i,
    input  logic      ready_i,
    output logic      advance_o,
    output logic      exm_valid_o,
    output rv32i_reg  exm_rd_o,
    output rv32i_word exm_result_o,
    output logic      wb_valid_o,
    output rv32i_reg  wb_rd_o,
    output rv32i_word wb_data_o,
    output rv32i_word wb_target_o,
    output logic      wb_br_en_o
);

    rv32i_word exm_target;
    logic      exm_br_en;

    // Both stages move as one, whenever the last slot drains or is empty
    assign advance_o = ready_i | ~wb_valid_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exm_valid_o <= 1'b0;
            wb_valid_o  <= 1'b0;
        end else if (advance_o) begin
            exm_valid_o <= valid_i;
            wb_valid_o  <= exm_valid_o;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_o) begin
            exm_rd_o     <= rd_i;
            exm_result_o <= result_i;
            exm_target   <= target_i;
            exm_br_en    <= br_en_i;
            wb_rd_o      <= exm_rd_o;     // Values pass along since nothing is done in memory
            wb_data_o    <= exm_result_o;
            wb_target_o  <= exm_target;
            wb_br_en_o   <= exm_br_en;
        end
    end

endmodule

// ==== rv32i_exe_top.sv ====
`timescale 1ns/1ns

module rv32i_exe_top
    import rv32i_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        valid_i,
    input  logic [31:0] instr_i,
    input  rv32i_word   pc_i,
    input  rv32i_word   rs1_data_i,
    input  rv32i_word   rs2_data_i,
    input  logic        ready_i,
    output logic        ready_o,
    output logic        wb_valid_o,
    output rv32i_reg    wb_rd_o,
    output rv32i_word   wb_data_o,
    output logic        wb_br_en_o,
    output rv32i_word   wb_target_o
);

    logic           dec_valid;
    rv32i_reg       dec_rs1;
    rv32i_reg       dec_rs2;
    rv32i_reg       dec_rd;
    alu_ops_t       dec_aluop;
    branch_funct3_t dec_cmpop;
    alumux1_sel_t   dec_alumux1_sel;
    alumux2_sel_t   dec_alumux2_sel;
    result_sel_t    dec_result_sel;
    logic           dec_is_branch;
    logic           dec_is_jump;
    rv32i_word      dec_imm;

    fwd_sel_t       rs1_sel;
    fwd_sel_t       rs2_sel;

    rv32i_word      exe_result;
    rv32i_word      exe_target;
    logic           exe_br_en;

    logic           exm_valid;
    rv32i_reg       exm_rd;
    rv32i_word      exm_result;

    ctrl_decode u_decode (
        .instr_i       (instr_i),
        .valid_i       (valid_i),
        .valid_o       (dec_valid),
        .rs1_o         (dec_rs1),
        .rs2_o         (dec_rs2),
        .rd_o          (dec_rd),
        .aluop_o       (dec_aluop),
        .cmpop_o       (dec_cmpop),
        .alumux1_sel_o (dec_alumux1_sel),
        .alumux2_sel_o (dec_alumux2_sel),
        .result_sel_o  (dec_result_sel),
        .is_branch_o   (dec_is_branch),
        .is_jump_o     (dec_is_jump),
        .imm_o         (dec_imm)
    );

    // The writeback slot doubles as the memory forward source
    fwd_unit u_fwd (
        .rs1_i       (dec_rs1),
        .rs2_i       (dec_rs2),
        .exm_valid_i (exm_valid),
        .mwb_valid_i (wb_valid_o),
        .exm_rd_i    (exm_rd),
        .mwb_rd_i    (wb_rd_o),
        .rs1_sel_o   (rs1_sel),
        .rs2_sel_o   (rs2_sel)
    );

    exe_stage u_exe (
        .aluop_i       (dec_aluop),
        .cmpop_i       (dec_cmpop),
        .alumux1_sel_i (dec_alumux1_sel),
        .alumux2_sel_i (dec_alumux2_sel),
        .result_sel_i  (dec_result_sel),
        .is_branch_i   (dec_is_branch),
        .is_jump_i     (dec_is_jump),
        .imm_i         (dec_imm),
        .pc_i          (pc_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .exe_fwd_i     (exm_result),
        .mem_fwd_i     (wb_data_o),
        .rs1_sel_i     (rs1_sel),
        .rs2_sel_i     (rs2_sel),
        .result_o      (exe_result),
        .target_o      (exe_target),
        .br_en_o       (exe_br_en)
    );

    pipe_regs u_pipe (
        .clk          (clk),
        .rst          (rst),
        .valid_i      (dec_valid),
        .rd_i         (dec_rd),
        .result_i     (exe_result),
        .target_i     (exe_target),
        .br_en_i      (exe_br_en),
        .ready_i      (ready_i),
        .advance_o    (ready_o),    // Upstream is accepted exactly when the stages shift
        .exm_valid_o  (exm_valid),
        .exm_rd_o     (exm_rd),
        .exm_result_o (exm_result),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .wb_target_o  (wb_target_o),
        .wb_br_en_o   (wb_br_en_o)
    );

endmodule

// ==== tb_rv32i_exe.sv ====
`timescale 1ns/1ns

module tb_rv32i_exe
    import rv32i_pkg::*;
();

    localparam int NUM_INSTR      = 2000;
    localparam int LAT_COUNT      = 200;    // Leading results checked with ready_i held high
    localparam int TIMEOUT_CYCLES = 4 * NUM_INSTR + 100;

    typedef struct packed {
        rv32i_reg  rd;
        rv32i_word data;
        logic      br_en;
        rv32i_word target;
        logic      lat_chk;
        int        acc_cycle;
    } exp_t;

    logic        clk;
    logic        rst;
    logic        valid_i;
    logic [31:0] instr_i;
    rv32i_word   pc_i;
    rv32i_word   rs1_data_i;
    rv32i_word   rs2_data_i;
    logic        ready_i;
    logic        ready_o;
    logic        wb_valid_o;
    rv32i_reg    wb_rd_o;
    rv32i_word   wb_data_o;
    logic        wb_br_en_o;
    rv32i_word   wb_target_o;

    exp_t        exp_q[$];
    rv32i_word   arch_regs[32];   // State as of the last accepted instruction
    rv32i_word   committed[32];   // State as of the last result taken downstream
    int          cycle_count;
    int          n_accepted;
    int          n_taken;
    int          stall_left;
    logic        running;
    logic        pending;
    logic [31:0] cur_instr;
    rv32i_word   cur_pc;

    rv32i_exe_top DUT (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (valid_i),
        .instr_i     (instr_i),
        .pc_i        (pc_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .ready_i     (ready_i),
        .ready_o     (ready_o),
        .wb_valid_o  (wb_valid_o),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o),
        .wb_br_en_o  (wb_br_en_o),
        .wb_target_o (wb_target_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // RV32I arithmetic and logic semantics per funct3 where alt selects SUB or SRA
    function automatic rv32i_word alu_ref(input logic [2:0] f3, input logic alt,
                                          input rv32i_word a, input rv32i_word b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'b000: alu_ref = alt ? a - b : a + b;
            3'b001: alu_ref = a << b[4:0];
            3'b010: alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: alu_ref = (a < b) ? 32'd1 : 32'd0;
            3'b100: alu_ref = a ^ b;
            3'b101: begin
                if (alt)
                    alu_ref = sa >>> b[4:0];
                else
                    alu_ref = a >> b[4:0];
            end
            3'b110: alu_ref = a | b;
            default: alu_ref = a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input rv32i_word a,
                                        input rv32i_word b);
        case (f3)
            3'b000:  branch_ref = (a == b);
            3'b001:  branch_ref = (a != b);
            3'b100:  branch_ref = ($signed(a) < $signed(b));
            3'b101:  branch_ref = ($signed(a) >= $signed(b));
            3'b110:  branch_ref = (a < b);
            default: branch_ref = (a >= b);
        endcase
    endfunction

    // Expected writeback tuple of one instruction against the architectural registers
    function automatic exp_t ref_model(input logic [31:0] instr, input rv32i_word pc);
        exp_t      e;
        rv32i_word a;
        rv32i_word b;
        rv32i_word imm_i;
        rv32i_word imm_u;
        rv32i_word imm_b;
        rv32i_word imm_j;
        a     = arch_regs[instr[19:15]];
        b     = arch_regs[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_u = {instr[31:12], 12'h000};
        imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        e     = '0;
        e.rd  = instr[11:7];
        case (instr[6:0])
            OP_REG:   e.data = alu_ref(instr[14:12], instr[30], a, b);
            OP_IMM:   e.data = alu_ref(instr[14:12], instr[30] & (instr[14:12] == 3'b101),
                                       a, imm_i);
            OP_LUI:   e.data = imm_u;
            OP_AUIPC: e.data = pc + imm_u;
            OP_JAL: begin
                e.data   = pc + 32'd4;
                e.br_en  = 1'b1;
                e.target = pc + imm_j;
            end
            OP_JALR: begin
                e.data   = pc + 32'd4;
                e.br_en  = 1'b1;
                e.target = (a + imm_i) & 32'hFFFF_FFFE;
            end
            OP_BR: begin
                e.rd     = '0;
                e.data   = pc + imm_b;  // The adder still forms pc plus offset
                e.target = pc + imm_b;
                e.br_en  = branch_ref(instr[14:12], a, b);
            end
            default: e = '0;
        endcase
        return e;
    endfunction

    // Legal instructions only, with registers x0 to x7 so that hazards are common
    function automatic logic [31:0] gen_instr();
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] r;
        rv32i_reg    rd;
        rv32i_reg    rs1;
        rv32i_reg    rs2;
        f3  = 3'($urandom_range(7));
        r   = $urandom();
        rd  = 5'($urandom_range(7));
        rs1 = 5'($urandom_range(7));
        rs2 = 5'($urandom_range(7));
        case ($urandom_range(11))
            0, 1, 2: begin
                f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[0]) ? 7'b0100000 : 7'b0000000;
                gen_instr = {f7, rs2, rs1, f3, rd, OP_REG};
            end
            3, 4, 5: begin
                if (f3 == 3'b001)
                    gen_instr = {7'b0000000, r[24:20], rs1, f3, rd, OP_IMM};
                else if (f3 == 3'b101)
                    gen_instr = {1'b0, r[0], 5'b00000, r[24:20], rs1, f3, rd, OP_IMM};
                else
                    gen_instr = {r[31:20], rs1, f3, rd, OP_IMM};
            end
            6: gen_instr = {r[31:12], rd, OP_LUI};
            7: gen_instr = {r[31:12], rd, OP_AUIPC};
            8: gen_instr = {r[31:12], rd, OP_JAL};
            9: gen_instr = {r[31:20], rs1, 3'b000, rd, OP_JALR};
            default: begin
                if (f3 == 3'b010 || f3 == 3'b011)
                    f3[2] = 1'b1;  // Map the two reserved codes onto BLTU and BGEU
                gen_instr = {r[31:25], rs2, rs1, f3, r[11:7], OP_BR};
            end
        endcase
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_word(input string name, input rv32i_word got, input rv32i_word exp);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_reg(input string name, input rv32i_reg got, input rv32i_reg exp);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s is x%0d, expected x%0d", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic drive_inputs();
        if (!pending && n_accepted < NUM_INSTR && $urandom_range(3) != 0) begin
            cur_instr = gen_instr();
            cur_pc    = $urandom() & 32'hFFFF_FFFC;
            pending   = 1'b1;
        end
        valid_i    = pending;
        instr_i    = pending ? cur_instr : $urandom();  // Junk while valid is low
        pc_i       = cur_pc;
        if (instr_i[6:0] == OP_LUI)
            rs1_data_i = committed[0];   // Decode forces the LUI source index to x0
        else
            rs1_data_i = committed[instr_i[19:15]];
        rs2_data_i = committed[instr_i[24:20]];
        if (n_taken < LAT_COUNT) begin
            ready_i = 1'b1;
        end else if (stall_left > 0) begin
            ready_i    = 1'b0;
            stall_left = stall_left - 1;
        end else if ($urandom_range(7) == 0) begin
            ready_i    = 1'b0;                  // Start a back-pressure burst
            stall_left = $urandom_range(4);
        end else begin
            ready_i = 1'b1;
        end
    endtask

    // Called between the falling edge and the rising edge that performs the handshake
    task automatic record_accept();
        exp_t e;
        if (valid_i && ready_o) begin
            e           = ref_model(instr_i, pc_i);
            e.lat_chk   = (n_accepted < LAT_COUNT);
            e.acc_cycle = cycle_count;
            exp_q.push_back(e);
            if (e.rd != '0)
                arch_regs[e.rd] = e.data;
            n_accepted = n_accepted + 1;
            pending    = 1'b0;
        end
    endtask

    task automatic compare_output();
        exp_t e;
        if (exp_q.size() == 0) begin
            abort_run("A result was handed downstream without any accepted instruction");
        end else begin
            e = exp_q.pop_front();
            check_reg("wb_rd_o", wb_rd_o, e.rd);
            check_word("wb_data_o", wb_data_o, e.data);
            check_bit("wb_br_en_o", wb_br_en_o, e.br_en);
            check_word("wb_target_o", wb_target_o, e.target);
            if (e.lat_chk && (cycle_count - e.acc_cycle != 2))
                abort_run($sformatf("A result arrived %0d cycles after acceptance instead of 2",
                                    cycle_count - e.acc_cycle));
            if (e.rd != '0)
                committed[e.rd] = e.data;
            n_taken = n_taken + 1;
        end
    endtask

    always begin
        @(negedge clk);
        #2;
        if (running && wb_valid_o && ready_i)
            compare_output();
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $fatal(1, "Timeout");
    end

    initial begin
        void'($urandom(69936));
        rst        = 1'b1;
        valid_i    = 1'b0;
        instr_i    = '0;
        pc_i       = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        ready_i    = 1'b0;
        running    = 1'b0;
        pending    = 1'b0;
        cur_instr  = '0;
        cur_pc     = '0;
        n_accepted = 0;
        n_taken    = 0;
        stall_left = 0;
        for (int i = 0; i < 32; i++) begin
            arch_regs[i] = '0;
            committed[i] = '0;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_bit("wb_valid_o", wb_valid_o, 1'b0);
        check_bit("ready_o", ready_o, 1'b1);
        running = 1'b1;

        while (n_taken < NUM_INSTR) begin
            @(negedge clk);
            drive_inputs();
            #1;
            record_accept();
        end

        // Idle cycles with ready_i high so that any stray result gets caught
        repeat (4) begin
            @(negedge clk);
            valid_i = 1'b0;
            ready_i = 1'b1;
        end

        if (exp_q.size() == 0 && n_accepted == NUM_INSTR) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("Accepted and delivered instruction counts do not match at the end");
            $display("*** FAILED ***");
            $fatal(1, "Count mismatch");
        end
    end

endmodule

// ==== rv32i_exe.f ====
rv32i_pkg.sv
alu.sv
cmp.sv
ctrl_decode.sv
fwd_unit.sv
exe_stage.sv
pipe_regs.sv
rv32i_exe_top.sv
tb_rv32i_exe.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv32i_exe
FILELIST  ?= rv32i_exe.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
